/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_key_uart_panel
RTL_TOP   ?= key_uart_panel
FILELIST  ?= key_uart_panel.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= CHECKS FAILED
VFLAGS    ?= --binary --timing --assert

SRCS     := $(shell grep -v '^+' $(FILELIST))
RTL_SRCS := $(filter-out sim/%,$(SRCS))
SIM_BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM_BIN) sim/panel_input.txt
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* common/panel_pkg.sv */
`default_nettype none

package panel_pkg;

	localparam int NUM_KEYS = 4;                        // keys on the board
	localparam int NUM_LEDS = 4;                        // leds show the low nibble

	// keys read low when pressed
	typedef logic [NUM_KEYS-1:0] key_vec_t;
	typedef logic [NUM_LEDS-1:0] led_vec_t;

endpackage

`default_nettype wire

/* common/uart_pkg.sv */
`default_nettype none

package uart_pkg;

	// **************************************************
	// serial frame
	// **************************************************
	localparam int DATA_BITS = 8;                       // 8N1, no parity

	typedef logic [DATA_BITS-1:0] uart_byte_t;

	// **************************************************
	// receiver and transmitter states
	// **************************************************
	typedef enum logic [1:0] {
		RX_IDLE,                                        // waiting for falling edge
		RX_START,                                       // half bit, confirm start level
		RX_DATA,                                        // eight data bits, lsb first
		RX_STOP                                         // stop bit must read high
	} rx_state_t;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_t;

endpackage

`default_nettype wire

/* hdl/key_debounce.sv */
`timescale 1ns/100ps
`default_nettype none

module key_debounce #(
	parameter int DEBOUNCE_CNT = 1000000                // stable clocks before accept
) (
	input  wire  sys_clk,
	input  wire  sys_rst_n,
	input  wire  key,                                   // raw, active low
	output logic key_value
);

	localparam int CNT_W = $clog2(DEBOUNCE_CNT + 1);
	localparam logic [CNT_W-1:0] RELOAD = CNT_W'(DEBOUNCE_CNT);

	logic [CNT_W-1:0] delay_cnt;
	logic             key_reg;

	// restart the countdown on any change of the raw level
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			key_reg   <= 1'b1;
			delay_cnt <= '0;
		end else begin
			key_reg <= key;
			if (key_reg != key)
				delay_cnt <= RELOAD;
			else if (delay_cnt != '0)
				delay_cnt <= delay_cnt - 1'b1;  // holds at zero once settled
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			key_value <= 1'b1;                          // released after reset
		else if (delay_cnt == CNT_W'(1))
			key_value <= key_reg;
	end

endmodule

`default_nettype wire

/* hdl/key_uart_panel.sv */
`timescale 1ns/100ps
`default_nettype none

module key_uart_panel #(
	parameter int CLK_DIV      = 25,                    // 2 Mbaud at 50 MHz
	parameter int DEBOUNCE_CNT = 1000000                // 20 ms at 50 MHz
) (
	input  wire                      sys_clk,
	input  wire                      sys_rst_n,
	input  wire panel_pkg::key_vec_t key,
	input  wire                      uart_rxd,
	output wire panel_pkg::led_vec_t led,
	output wire                      uart_txd
);
	import uart_pkg::*;
	import panel_pkg::*;

	wire key_vec_t   key_stable;
	wire             rx_valid;
	wire uart_byte_t rx_data;
	wire             tx_valid;
	wire             tx_ready;
	wire uart_byte_t tx_data;

	// one debouncer per key
	for (genvar i = 0; i < NUM_KEYS; i++) begin : g_key
		key_debounce #(
			.DEBOUNCE_CNT (DEBOUNCE_CNT)
		) u_key_debounce (
			.sys_clk   (sys_clk),
			.sys_rst_n (sys_rst_n),
			.key       (key[i]),
			.key_value (key_stable[i])
		);
	end

	uart_rx #(
		.CLK_DIV (CLK_DIV)
	) u_uart_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.uart_rxd  (uart_rxd),
		.rx_valid  (rx_valid),
		.rx_data   (rx_data)
	);

	uart_tx #(
		.CLK_DIV (CLK_DIV)
	) u_uart_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_valid  (tx_valid),
		.tx_data   (tx_data),
		.tx_ready  (tx_ready),
		.uart_txd  (uart_txd)
	);

	panel_ctrl u_panel_ctrl (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.key_stable (key_stable),
		.rx_valid   (rx_valid),
		.rx_data    (rx_data),
		.tx_ready   (tx_ready),
		.tx_valid   (tx_valid),
		.tx_data    (tx_data),
		.led        (led)
	);

endmodule

`default_nettype wire

/* hdl/panel_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module panel_ctrl (
	input  wire                       sys_clk,
	input  wire                       sys_rst_n,
	input  wire panel_pkg::key_vec_t  key_stable,       // debounced, active low
	input  wire                       rx_valid,
	input  wire uart_pkg::uart_byte_t rx_data,
	input  wire                       tx_ready,
	output logic                      tx_valid,
	output uart_pkg::uart_byte_t      tx_data,
	output panel_pkg::led_vec_t       led
);
	import uart_pkg::*;
	import panel_pkg::*;

	uart_byte_t rx_store;                               // last good received byte
	logic       key0_last;
	logic       key0_press;

	assign key0_press = key0_last & ~key_stable[0];

	// **************************************************
	// receive side
	// **************************************************
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			led      <= '0;
			rx_store <= '0;
		end else if (rx_valid) begin
			led      <= rx_data[NUM_LEDS-1:0];
			rx_store <= rx_data;
		end
	end

	// **************************************************
	// key 0 press, one request per press
	// **************************************************
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			key0_last <= 1'b1;
			tx_valid  <= 1'b0;
		end else begin
			key0_last <= key_stable[0];
			if (tx_valid && tx_ready)
				tx_valid <= 1'b0;                       // byte accepted
			else if (key0_press)
				tx_valid <= 1'b1;
		end
	end

	// press while a request is pending is ignored
	always_ff @(posedge sys_clk) begin
		if (key0_press && !tx_valid)
			tx_data <= {rx_store[DATA_BITS-1:3], key_stable[NUM_KEYS-1:1]};
	end

endmodule

`default_nettype wire

/* key_uart_panel.f */
common/uart_pkg.sv
common/panel_pkg.sv
hdl/key_debounce.sv
uart/uart_rx.sv
uart/uart_tx.sv
hdl/panel_ctrl.sv
hdl/key_uart_panel.sv
sim/key_uart_panel_sva.sv
sim/tb_key_uart_panel.sv

/* sim/key_uart_panel_sva.sv */
`timescale 1ns/100ps
`default_nettype none

module key_uart_panel_sva (
	input wire                       sys_clk,
	input wire                       sys_rst_n,
	input wire                       tx_valid,
	input wire uart_pkg::uart_byte_t tx_data,
	input wire                       tx_ready,
	input wire                       uart_txd,
	input wire uart_pkg::tx_state_t  state
);
	import uart_pkg::*;

	// **************************************************
	// transmitter handshake and line level
	// **************************************************
	a_data_held: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		(tx_valid && !tx_ready) |=> (tx_data == $past(tx_data)))  // pending byte frozen
		else $error("tx_data changed while waiting for tx_ready");

	a_idle_high: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		(state == TX_IDLE) |-> uart_txd)
		else $error("uart_txd low while the transmitter is idle");

	a_ready_reset: assert property (@(posedge sys_clk)
		$rose(sys_rst_n) |-> tx_ready)                  // first cycle out of reset
		else $error("tx_ready low right after reset");

endmodule

bind uart_tx key_uart_panel_sva u_tx_sva (
	.sys_clk   (sys_clk),
	.sys_rst_n (sys_rst_n),
	.tx_valid  (tx_valid),
	.tx_data   (tx_data),
	.tx_ready  (tx_ready),
	.uart_txd  (uart_txd),
	.state     (state)
);

`default_nettype wire

/* sim/panel_input.txt */
# op a b, one operation per line, a in hex and b in decimal
# 1 rx byte a with stop bit b | 2 keys a held b cycles | 3 b bounce pulses on key 0
# 4 expect led a | 5 expect tx byte a | 6 expect no tx byte
4 0 0
6 0 0
1 a5 1
4 5 0
1 3c 1
4 c 0
1 97 1
4 7 0
1 e2 0
4 7 0
2 a 24
5 95 0
2 f 24
6 0 0
3 0 6
6 0 0
2 6 200
5 93 0
6 0 0
2 f 24
1 5b 1
4 b 0
2 e 24
2 f 24
2 8 40
5 5f 0
5 5c 0
2 f 24
6 0 0

/* sim/tb_key_uart_panel.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_key_uart_panel;
	import uart_pkg::*;
	import panel_pkg::*;

	localparam int CLK_DIV      = 8;
	localparam int DEBOUNCE_CNT = 16;
	localparam int CLK_HALF     = 20;                   // 40 ns period
	localparam int LINE_CYCLES  = 12 * CLK_DIV + 4 * DEBOUNCE_CNT + 50;
	localparam int TX_WAIT      = 24 * CLK_DIV + 2 * DEBOUNCE_CNT;
	localparam string INPUT_FILE = "sim/panel_input.txt";

	logic          sys_clk;
	logic          sys_rst_n;
	key_vec_t      key;
	logic          uart_rxd;
	wire led_vec_t led;
	wire           uart_txd;

	int         value_errors = 0;
	int         xfer_errors  = 0;
	int         line_count   = 0;
	int         seed         = 49;
	uart_byte_t tx_seen[$];                             // bytes seen on uart_txd
	uart_byte_t tx_model[$];                            // bytes the model predicts
	uart_byte_t model_store = '0;
	led_vec_t   model_led   = '0;
	key_vec_t   model_keys  = '1;

	key_uart_panel #(
		.CLK_DIV      (CLK_DIV),
		.DEBOUNCE_CNT (DEBOUNCE_CNT)
	) u_dut (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.key       (key),
		.uart_rxd  (uart_rxd),
		.led       (led),
		.uart_txd  (uart_txd)
	);

	initial begin
		sys_clk = 1'b0;
		forever #CLK_HALF sys_clk = ~sys_clk;
	end

	// **************************************************
	// stimulus tasks, each starts and ends on a rising edge
	// **************************************************
	task automatic send_serial(input uart_byte_t data, input logic stop);
		logic [9:0] frame;
		frame = {stop, data, 1'b0};
		for (int i = 0; i < 10; i++) begin
			#2 uart_rxd = frame[i];                     // start bit first, then lsb
			repeat (CLK_DIV) @(posedge sys_clk);
		end
		#2 uart_rxd = 1'b1;
		repeat (2 * CLK_DIV) @(posedge sys_clk);        // idle gap
		if (stop) begin
			model_store = data;
			model_led   = data[3:0];
		end
	endtask

	task automatic apply_keys(input key_vec_t level, input int hold);
		#2 key = level;
		repeat (hold) @(posedge sys_clk);
		if (hold >= DEBOUNCE_CNT + 2) begin
			if (model_keys[0] && !level[0])
				tx_model.push_back({model_store[7:3], level[3:1]});
			model_keys = level;
		end
	endtask

	// key 0 pulses, every segment shorter than the debounce time
	task automatic bounce_key0(input int pulses);
		int len;
		for (int i = 0; i < pulses; i++) begin
			len = 1 + ($unsigned($random(seed)) % (DEBOUNCE_CNT - 4));
			#2 key[0] = 1'b0;
			repeat (len) @(posedge sys_clk);
			len = 1 + ($unsigned($random(seed)) % (DEBOUNCE_CNT - 4));
			#2 key[0] = 1'b1;
			repeat (len) @(posedge sys_clk);
		end
		repeat (DEBOUNCE_CNT + 8) @(posedge sys_clk);
	endtask

	// **************************************************
	// checks
	// **************************************************
	task automatic check_led(input led_vec_t want);
		@(negedge sys_clk);
		if (want !== model_led) begin
			$display("Fail %0t: data file expects led %h, model gives %h", $time, want, model_led);
			value_errors++;
		end
		if (led !== want) begin
			$display("Fail %0t: led is %h, expected %h", $time, led, want);
			value_errors++;
		end
		@(posedge sys_clk);
	endtask

	task automatic expect_tx(input uart_byte_t want);
		int         waited;
		uart_byte_t got;
		uart_byte_t predicted;
		waited = 0;
		while (tx_seen.size() == 0 && waited < TX_WAIT) begin
			@(negedge sys_clk);
			waited++;
		end
		if (tx_model.size() == 0) begin
			$display("model predicts no byte where the data file expects %h", want);
			xfer_errors++;
		end else begin
			predicted = tx_model.pop_front();
			if (predicted !== want) begin
				$display("Fail %0t: data file expects tx %h, model gives %h", $time, want, predicted);
				value_errors++;
			end
		end
		if (tx_seen.size() == 0) begin
			$display("no byte was transmitted where %h was expected", want);
			xfer_errors++;
		end else begin
			got = tx_seen.pop_front();
			if (got !== want) begin
				$display("Fail %0t: transmitted %h, expected %h", $time, got, want);
				value_errors++;
			end
		end
		@(posedge sys_clk);
	endtask

	task automatic expect_quiet();
		repeat (12 * CLK_DIV) @(posedge sys_clk);       // longer than one frame
		if (tx_seen.size() != 0) begin
			$display("%0d unexpected byte(s) transmitted, first %h", tx_seen.size(), tx_seen[0]);
			xfer_errors++;
			tx_seen.delete();
		end
	endtask

	task automatic run_op(input int op, input logic [31:0] arg_a, input int arg_b);
		case (op)
			1: send_serial(arg_a[7:0], arg_b[0]);
			2: apply_keys(arg_a[3:0], arg_b);
			3: bounce_key0(arg_b);
			4: check_led(arg_a[3:0]);
			5: expect_tx(arg_a[7:0]);
			6: expect_quiet();
			default: begin
				$display("unknown operation %0d in the data file", op);
				xfer_errors++;
			end
		endcase
	endtask

	task automatic count_lines(output int count);
		int               fd;
		logic [8*128-1:0] line;
		count = 0;
		fd = $fopen(INPUT_FILE, "r");
		if (fd != 0) begin
			while ($fgets(line, fd) > 0)
				count++;
			$fclose(fd);
		end
	endtask

	// **************************************************
	// serial monitor on uart_txd, samples mid-bit
	// **************************************************
	initial begin : tx_monitor
		uart_byte_t frame_bits;
		forever begin
			@(negedge uart_txd);
			repeat (CLK_DIV / 2) @(negedge sys_clk);
			if (uart_txd !== 1'b0) begin
				$display("start bit on uart_txd did not hold low at %0t", $time);
				xfer_errors++;
			end else begin
				for (int i = 0; i < 8; i++) begin
					repeat (CLK_DIV) @(negedge sys_clk);
					frame_bits[i] = uart_txd;           // lsb first
				end
				repeat (CLK_DIV) @(negedge sys_clk);
				if (uart_txd !== 1'b1) begin
					$display("stop bit on uart_txd was low at %0t", $time);
					xfer_errors++;
				end
				tx_seen.push_back(frame_bits);
			end
		end
	end

	initial begin : watchdog
		wait (line_count > 0);
		repeat (line_count * LINE_CYCLES) @(posedge sys_clk);
		$display("watchdog expired after %0d cycles, the run did not finish", line_count * LINE_CYCLES);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin : main_flow
		int               fd;
		int               fields;
		int               op;
		logic [31:0]      arg_a;
		int               arg_b;
		logic [8*128-1:0] line;
		sys_rst_n = 1'b0;
		key       = '1;                                 // all keys released
		uart_rxd  = 1'b1;
		count_lines(line_count);
		repeat (8) @(posedge sys_clk);
		#2 sys_rst_n = 1'b1;
		@(posedge sys_clk);
		fd = $fopen(INPUT_FILE, "r");
		if (fd == 0) begin
			$display("cannot open %s", INPUT_FILE);
			xfer_errors++;
		end else begin
			while (!$feof(fd)) begin
				line = '0;
				if ($fgets(line, fd) > 0) begin
					fields = $sscanf(line, "%h %h %d", op, arg_a, arg_b);
					if (fields == 3)                    // comment lines do not parse
						run_op(op, arg_a, arg_b);
				end
			end
			$fclose(fd);
		end
		if (tx_seen.size() != 0) begin
			$display("%0d transmitted byte(s) were never checked", tx_seen.size());
			xfer_errors++;
		end
		if (tx_model.size() != 0) begin
			$display("%0d predicted byte(s) have no check in the data file", tx_model.size());
			xfer_errors++;
		end
		$display("summary: %0d value errors, %0d transfer errors", value_errors, xfer_errors);
		if (value_errors == 0 && xfer_errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* uart/uart_rx.sv */
`timescale 1ns/100ps
`default_nettype none

module uart_rx #(
	parameter int CLK_DIV = 25                          // clocks per bit
) (
	input  wire                  sys_clk,
	input  wire                  sys_rst_n,
	input  wire                  uart_rxd,
	output logic                 rx_valid,              // one cycle per good frame
	output uart_pkg::uart_byte_t rx_data
);
	import uart_pkg::*;

	localparam int CNT_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
	localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(CLK_DIV - 1);
	localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLK_DIV / 2 - 1);
	localparam int IDX_W = $clog2(DATA_BITS);
	localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(DATA_BITS - 1);

	rx_state_t        state;
	logic [CNT_W-1:0] clk_cnt;                          // clocks into current bit
	logic [IDX_W-1:0] bit_idx;
	logic             rxd_meta;
	logic             rxd_sync;
	logic             rxd_last;                         // for edge detection
	logic             start_edge;

	assign start_edge = rxd_last & ~rxd_sync;

	// line idles high, so the sync chain resets high
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
			rxd_last <= 1'b1;
		end else begin
			rxd_meta <= uart_rxd;
			rxd_sync <= rxd_meta;
			rxd_last <= rxd_sync;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= RX_IDLE;
			clk_cnt  <= '0;
			bit_idx  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			clk_cnt  <= clk_cnt + 1'b1;
			case (state)
				RX_IDLE: begin
					clk_cnt <= '0;
					bit_idx <= '0;
					if (start_edge)
						state <= RX_START;
				end
				RX_START: begin
					if (clk_cnt == HALF_LAST) begin    // middle of start bit
						clk_cnt <= '0;
						if (rxd_sync)
							state <= RX_IDLE;           // glitch, not a start bit
						else
							state <= RX_DATA;
					end
				end
				RX_DATA: begin
					if (clk_cnt == BIT_LAST) begin
						clk_cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == IDX_LAST)
							state <= RX_STOP;
					end
				end
				RX_STOP: begin
					if (clk_cnt == BIT_LAST) begin
						rx_valid <= rxd_sync;           // low stop bit drops the frame
						state    <= RX_IDLE;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// shift in at mid-bit, lsb arrives first
	always_ff @(posedge sys_clk) begin
		if (state == RX_DATA && clk_cnt == BIT_LAST)
			rx_data <= {rxd_sync, rx_data[DATA_BITS-1:1]};
	end

endmodule

`default_nettype wire

/* uart/uart_tx.sv */
`timescale 1ns/100ps
`default_nettype none

module uart_tx #(
	parameter int CLK_DIV = 25
) (
	input  wire                       sys_clk,
	input  wire                       sys_rst_n,
	input  wire                       tx_valid,
	input  wire uart_pkg::uart_byte_t tx_data,
	output logic                      tx_ready,
	output logic                      uart_txd            // registered line output
);
	import uart_pkg::*;

	localparam int CNT_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
	localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLK_DIV - 1);
	localparam int IDX_W = $clog2(DATA_BITS);
	localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(DATA_BITS - 1);

	tx_state_t        state;
	logic [CNT_W-1:0] clk_cnt;
	logic [IDX_W-1:0] bit_idx;
	uart_byte_t       tx_shift;                         // next bit sits in bit 0
	logic             xfer;
	logic             bit_end;

	assign tx_ready = (state == TX_IDLE);
	assign xfer     = tx_valid & tx_ready;
	assign bit_end  = (clk_cnt == BIT_LAST);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= TX_IDLE;
			clk_cnt  <= '0;
			bit_idx  <= '0;
			uart_txd <= 1'b1;
		end else begin
			clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
			case (state)
				TX_IDLE: begin
					clk_cnt <= '0;
					bit_idx <= '0;
					if (xfer) begin
						state    <= TX_START;
						uart_txd <= 1'b0;           // start bit
					end
				end
				TX_START: begin
					if (bit_end) begin
						state    <= TX_DATA;
						uart_txd <= tx_shift[0];
					end
				end
				TX_DATA: begin
					if (bit_end) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == IDX_LAST) begin
							state    <= TX_STOP;
							uart_txd <= 1'b1;       // stop bit
						end else begin
							uart_txd <= tx_shift[0];
						end
					end
				end
				TX_STOP: begin
					if (bit_end)
						state <= TX_IDLE;           // ready again after full stop bit
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (xfer)
			tx_shift <= tx_data;
		else if (bit_end && (state == TX_START || state == TX_DATA))
			tx_shift <= tx_shift >> 1;
	end

endmodule

`default_nettype wire
